/* tb.f */
+incdir+testbench
verilog/fp16_pkg.sv
verilog/sa_pkg.sv
verilog/fp16_mul.sv
verilog/fp16_add.sv
verilog/sa_pe.sv
verilog/sa_array.sv
verilog/sa_top.sv
testbench/tb_sa_top.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_sa_top -f tb.f -o sim_tb
out=$(./obj_dir/sim_tb) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx 'Result: PASSED'; then
    exit 0
fi
exit 1

/* testbench/fp16_model.svh */
/* fp16 reference model
   Multiply, add and 2x2 matrix product under the simplified half-precision rules */
`ifndef FP16_MODEL_SVH
`define FP16_MODEL_SVH

// Truncating multiply, zero and infinity keep the product sign
function automatic fp16_t mul_fp16(fp16_t a, fp16_t b);
    fp16_t       y;
    int unsigned sig;
    int          e;
    y      = '0;
    y.sign = a.sign ^ b.sign;
    if (a.exp == 0 || b.exp == 0)
        return y;                                      // Zero operand
    sig = (32'd1024 + a.man) * (32'd1024 + b.man);     // Significands with hidden one
    e   = int'(a.exp) + int'(b.exp) - EXP_BIAS;
    if (sig >= (32'd1 << (PROD_W - 1))) begin
        sig = sig >> (MAN_W + 1);                      // Product in [2,4)
        e   = e + 1;
    end else begin
        sig = sig >> MAN_W;
    end
    if (e < 1)
        return y;                                      // Underflow
    if (e >= EXP_MAX) begin
        y.exp = EXP_W'(EXP_MAX);                       // Overflow to infinity
        return y;
    end
    y.exp = EXP_W'(e);
    y.man = sig[MAN_W-1:0];
    return y;
endfunction

// Same-sign add, mixed signs give +0
function automatic fp16_t add_fp16(fp16_t a, fp16_t b);
    fp16_t       big;
    fp16_t       lesser;
    fp16_t       y;
    int unsigned sig;
    int          e;
    if (a[EXP_W+MAN_W-1:0] >= b[EXP_W+MAN_W-1:0]) begin
        big    = a;
        lesser = b;
    end else begin
        big    = b;
        lesser = a;
    end
    if (lesser.exp == 0)
        return big;                                    // Zero adds nothing
    y      = '0;
    y.sign = big.sign;
    if (big.exp == EXP_W'(EXP_MAX)) begin
        y.exp = EXP_W'(EXP_MAX);
        return y;
    end
    if (big.sign != lesser.sign)
        return '0;
    // Align the smaller one, bits shifted out are lost
    sig = (32'd1024 + big.man) + ((32'd1024 + lesser.man) >> (big.exp - lesser.exp));
    e   = int'(big.exp);
    if (sig >= 32'd2048) begin
        sig = sig >> 1;                                // Carry renormalizes
        e   = e + 1;
    end
    y.exp = EXP_W'(e);
    if (e < EXP_MAX)
        y.man = sig[MAN_W-1:0];
    return y;
endfunction

// One C entry, top row product added first as it flows down the column
function automatic fp16_t dot2(fp16_t x0, fp16_t x1, fp16_t w0, fp16_t w1);
    return add_fp16(add_fp16('0, mul_fp16(x0, w0)), mul_fp16(x1, w1));
endfunction

function automatic mat_t ref_matmul(mat_t a, mat_t b);
    mat_t c;
    c.m00 = dot2(a.m00, a.m01, b.m00, b.m10);
    c.m01 = dot2(a.m00, a.m01, b.m01, b.m11);
    c.m10 = dot2(a.m10, a.m11, b.m00, b.m10);
    c.m11 = dot2(a.m10, a.m11, b.m01, b.m11);
    return c;
endfunction

`endif

/* testbench/tb_sa_top.sv */
/* Testbench for the 2x2 fp16 systolic array
   Identity, random, overflow and ignored-go runs checked against the reference model */
`timescale 1ns/1ps
`default_nettype none

module tb_sa_top;

    import fp16_pkg::*;
    import sa_pkg::*;

    localparam int RST_CYCLES  = 4;
    localparam int DONE_CYCLE  = 7;     // done in the 7th cycle after go is sampled
    localparam int N_IDENT     = 8;
    localparam int N_RAND      = 40;
    localparam int N_EDGE      = 4;
    localparam int N_IGNORE    = 3;
    localparam int RUNS        = N_IDENT + N_RAND + N_EDGE + N_IGNORE;
    localparam int WATCHDOG_NS = (RUNS * 12 + RST_CYCLES) * 20 * 2;

    logic clk = 1'b0;
    logic rst;
    logic go;
    mat_t a_mat;
    mat_t b_mat;
    logic busy;
    logic done;
    mat_t c_mat;

    mat_t exp_q[$];        // Expected results in go order
    mat_t held_c = '0;     // c_mat must stay here between dones
    mat_t want;

    `include "fp16_model.svh"

    sa_top i_sa_top (
        .clk   (clk),
        .rst   (rst),
        .go    (go),
        .a_mat (a_mat),
        .b_mat (b_mat),
        .busy  (busy),
        .done  (done),
        .c_mat (c_mat)
    );

    always #10 clk = ~clk;   // 20 ns period

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped");
    endtask

    // Positive value, exponent drawn from lo..hi
    function automatic fp16_t rand_fp16(input int lo, input int hi);
        fp16_t v;
        v.sign = 1'b0;
        v.exp  = EXP_W'($urandom_range(hi, lo));
        v.man  = MAN_W'($urandom);
        return v;
    endfunction

    function automatic mat_t rand_mat(input int lo, input int hi);
        mat_t m;
        m.m00 = rand_fp16(lo, hi);
        m.m01 = rand_fp16(lo, hi);
        m.m10 = rand_fp16(lo, hi);
        m.m11 = rand_fp16(lo, hi);
        return m;
    endfunction

    task automatic check_entry(input string name, input fp16_t got, input fp16_t exp_v);
        assert (got === exp_v)
        else report_failure($sformatf("error: %s got %h expected %h", name, got, exp_v));
    endtask

    // One go pulse, then busy and done checked every cycle up to done
    task automatic run_product(input mat_t a, input mat_t b, input mat_t want_c, input bit poke);
        @(posedge clk);
        #1;
        a_mat = a;
        b_mat = b;
        go    = 1'b1;
        exp_q.push_back(want_c);
        for (int cyc = 1; cyc <= DONE_CYCLE; cyc++) begin
            @(posedge clk);                  // Edge cyc-1
            #1;
            go = poke && (cyc == 3);         // Lands in the middle of RUN
            if (go) begin
                a_mat = rand_mat(8, 22);     // Must not reach the array
                b_mat = rand_mat(8, 22);
            end
            @(negedge clk);
            assert (busy === (cyc < DONE_CYCLE))
            else report_failure($sformatf("error: busy got %h expected %h in cycle %0d",
                                          busy, cyc < DONE_CYCLE, cyc));
            assert (done === (cyc == DONE_CYCLE))
            else report_failure($sformatf("error: done got %h expected %h in cycle %0d",
                                          done, cyc == DONE_CYCLE, cyc));
        end
    endtask

    // Compares on every done, checks the hold in between
    always @(negedge clk) begin
        if (rst && done) begin
            assert (exp_q.size() > 0) else report_failure("done pulsed with no run pending");
            want = exp_q.pop_front();
            check_entry("c_mat.m00", c_mat.m00, want.m00);
            check_entry("c_mat.m01", c_mat.m01, want.m01);
            check_entry("c_mat.m10", c_mat.m10, want.m10);
            check_entry("c_mat.m11", c_mat.m11, want.m11);
            held_c = c_mat;
        end else if (rst) begin
            assert (c_mat === held_c)
            else report_failure($sformatf("error: c_mat got %h expected %h", c_mat, held_c));
        end
    end

    initial begin : stimulus
        mat_t ident;
        mat_t a;
        mat_t b;
        mat_t c_ref;
        void'($urandom(32'h5262_a915));
        rst       = 1'b0;
        go        = 1'b0;
        a_mat     = '0;
        b_mat     = '0;
        ident     = '0;
        ident.m00 = 16'h3C00;   // 1.0
        ident.m11 = 16'h3C00;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst = 1'b1;
        @(negedge clk);
        assert (busy === 1'b0)
        else report_failure($sformatf("error: busy got %h expected 0 after reset", busy));
        assert (done === 1'b0)
        else report_failure($sformatf("error: done got %h expected 0 after reset", done));
        assert (c_mat === '0)
        else report_failure($sformatf("error: c_mat got %h expected 0 after reset", c_mat));

        for (int i = 0; i < N_IDENT; i++) begin
            a = rand_mat(1, 30);
            run_product(a, ident, a, 1'b0);   // Times 1.0 plus zeros is exact
        end
        for (int i = 0; i < N_RAND; i++) begin
            a = rand_mat(8, 22);
            b = rand_mat(8, 22);
            run_product(a, b, ref_matmul(a, b), 1'b0);
        end

        // Large exponents saturate, tiny ones flush
        a     = rand_mat(28, 30);
        b     = rand_mat(28, 30);
        c_ref = ref_matmul(a, b);
        assert (c_ref === {4{16'h7C00}})
        else report_failure("reference model gave no infinity for the overflow run");
        run_product(a, b, c_ref, 1'b0);
        a     = rand_mat(1, 5);
        b     = rand_mat(1, 5);
        c_ref = ref_matmul(a, b);
        assert (c_ref === '0)
        else report_failure("reference model gave no zero for the underflow run");
        run_product(a, b, c_ref, 1'b0);
        for (int i = 2; i < N_EDGE; i++) begin
            a = rand_mat(1, 30);
            b = rand_mat(1, 30);
            run_product(a, b, ref_matmul(a, b), 1'b0);
        end

        for (int i = 0; i < N_IGNORE; i++) begin
            a = rand_mat(8, 22);
            b = rand_mat(8, 22);
            run_product(a, b, ref_matmul(a, b), 1'b1);
        end

        repeat (2) @(posedge clk);
        if (exp_q.size() == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            report_failure("runs ended with results still pending");
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        report_failure($sformatf("timeout after %0d ns, runs did not complete", WATCHDOG_NS));
    end

endmodule

`default_nettype wire

/* verilog/sa_top.sv */
/* Systolic array top with controller
   Sequences load and run on a go strobe and reports busy and a done pulse */
`timescale 1ns/1ps
`default_nettype none

module sa_top (
    input  logic         clk,
    input  logic         rst,
    input  logic         go,
    input  sa_pkg::mat_t a_mat,
    input  sa_pkg::mat_t b_mat,
    output logic         busy,
    output logic         done,
    output sa_pkg::mat_t c_mat
);

    import sa_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    logic        load;         // Weights and feeders take A and B
    logic        compute;      // Array steps
    logic        array_done;   // Last run step

    sa_array i_array (
        .clk        (clk),
        .rst        (rst),
        .load       (load),
        .compute    (compute),
        .a_mat      (a_mat),
        .b_mat      (b_mat),
        .c_mat      (c_mat),
        .array_done (array_done)
    );

    always_ff @(posedge clk) begin
        if (!rst)
            state <= IDLE;
        else
            state <= state_nxt;
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (go) state_nxt = LOAD;
            LOAD:    state_nxt = RUN;              // Single load cycle
            RUN:     if (array_done) state_nxt = DONE;
            DONE:    state_nxt = IDLE;             // Result flagged for one cycle
            default: state_nxt = IDLE;
        endcase
    end

    assign load    = (state == LOAD);
    assign compute = (state == RUN);
    assign busy    = (state == LOAD) || (state == RUN);   // go ignored while high
    assign done    = (state == DONE);

    // Array step counter must line up with the controller, done 7 cycles after go
    a_done_single: assert property (
        @(posedge clk) disable iff (!rst) (state == IDLE && go) |-> ##7 done);

endmodule

`default_nettype wire

/* verilog/sa_array.sv */
/* 2x2 weight-stationary array
   Skewed A feeders, PE grid, column delay lines, step counter and result capture */
`timescale 1ns/1ps
`default_nettype none

module sa_array (
    input  logic         clk,
    input  logic         rst,
    input  logic         load,
    input  logic         compute,
    input  sa_pkg::mat_t a_mat,
    input  sa_pkg::mat_t b_mat,
    output sa_pkg::mat_t c_mat,
    output logic         array_done
);

    import fp16_pkg::*;
    import sa_pkg::*;

    fp16_t             a_elem [N][N];           // A as [row][col]
    fp16_t             b_elem [N][N];           // B as [row][col]
    fp16_t             feed   [N][FEED_LEN];    // Per-row activation queue, slot 0 feeds the PE
    fp16_t             act    [N][N];           // West input of PE(r,c)
    fp16_t             psum   [N+1][N];         // North input of PE(r,c), row N is the bottom
    fp16_t             dly    [N][DLY_LEN];     // Per-column product delay
    fp16_t             tap    [N][DLY_LEN+1];   // Tap 0 is the live bottom sum
    mat_t              c_next;
    logic [STEP_W-1:0] step_cnt;

    always_comb begin
        a_elem[0][0] = a_mat.m00;
        a_elem[0][1] = a_mat.m01;
        a_elem[1][0] = a_mat.m10;
        a_elem[1][1] = a_mat.m11;
        b_elem[0][0] = b_mat.m00;
        b_elem[0][1] = b_mat.m01;
        b_elem[1][0] = b_mat.m10;
        b_elem[1][1] = b_mat.m11;
    end

    // Row r carries column r of A, skewed r slots back
    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int r = 0; r < N; r++)
                for (int i = 0; i < FEED_LEN; i++)
                    feed[r][i] <= '0;
        end else if (load) begin
            for (int r = 0; r < N; r++) begin
                for (int i = 0; i < FEED_LEN; i++)
                    feed[r][i] <= '0;
                for (int k = 0; k < N; k++)
                    feed[r][k+r] <= a_elem[k][r];   // Overrides the clear above
            end
        end else if (compute) begin
            for (int r = 0; r < N; r++) begin
                for (int i = 0; i < FEED_LEN - 1; i++)
                    feed[r][i] <= feed[r][i+1];
                feed[r][FEED_LEN-1] <= '0;   // Zeros trail the data
            end
        end
    end

    genvar r, c;
    for (r = 0; r < N; r++) begin : g_row
        assign act[r][0] = feed[r][0];
        for (c = 0; c < N; c++) begin : g_col
            if (r == 0) begin : g_top
                assign psum[0][c] = '0;   // Nothing from the north edge
            end
            if (c < N - 1) begin : g_mid
                sa_pe i_pe (
                    .clk        (clk),
                    .rst        (rst),
                    .compute    (compute),
                    .weight_en  (load),
                    .weight_in  (b_elem[r][c]),
                    .act_west   (act[r][c]),
                    .psum_north (psum[r][c]),
                    .act_east   (act[r][c+1]),
                    .psum_south (psum[r+1][c])
                );
            end else begin : g_edge
                // East edge, activation leaves the array
                sa_pe i_pe (
                    .clk        (clk),
                    .rst        (rst),
                    .compute    (compute),
                    .weight_en  (load),
                    .weight_in  (b_elem[r][c]),
                    .act_west   (act[r][c]),
                    .psum_north (psum[r][c]),
                    .act_east   (),
                    .psum_south (psum[r+1][c])
                );
            end
        end
    end

    always_comb begin
        for (int k = 0; k < N; k++) begin
            tap[k][0] = psum[N][k];
            for (int j = 0; j < DLY_LEN; j++)
                tap[k][j+1] = dly[k][j];
        end
    end

    // C[k][c] sits at tap DLY_LEN-(k+c) on the last step
    always_comb begin
        c_next.m00 = tap[0][DLY_LEN];
        c_next.m01 = tap[1][DLY_LEN-1];
        c_next.m10 = tap[0][DLY_LEN-1];
        c_next.m11 = tap[1][DLY_LEN-2];
    end

    assign array_done = compute && (step_cnt == STEP_W'(RUN_STEPS - 1));

    always_ff @(posedge clk) begin
        if (!rst) begin
            step_cnt <= '0;
            c_mat    <= '0;
            for (int k = 0; k < N; k++)
                for (int j = 0; j < DLY_LEN; j++)
                    dly[k][j] <= '0;
        end else if (compute) begin
            for (int k = 0; k < N; k++) begin
                dly[k][0] <= psum[N][k];
                for (int j = 1; j < DLY_LEN; j++)
                    dly[k][j] <= dly[k][j-1];
            end
            if (array_done) begin
                step_cnt <= '0;
                c_mat    <= c_next;   // Held until the next run ends
            end else begin
                step_cnt <= step_cnt + 1'b1;
            end
        end
    end

    // Controller never overlaps the two phases
    a_load_compute_excl: assert property (
        @(posedge clk) disable iff (!rst) !(load && compute));

endmodule

`default_nettype wire

/* verilog/sa_pe.sv */
/* Systolic processing element
   Holds one weight, forwards activations east and accumulated sums south */
`timescale 1ns/1ps
`default_nettype none

module sa_pe (
    input  logic            clk,
    input  logic            rst,
    input  logic            compute,
    input  logic            weight_en,
    input  fp16_pkg::fp16_t weight_in,
    input  fp16_pkg::fp16_t act_west,
    input  fp16_pkg::fp16_t psum_north,
    output fp16_pkg::fp16_t act_east,
    output fp16_pkg::fp16_t psum_south
);

    import fp16_pkg::*;

    fp16_t weight;   // Stationary B element
    fp16_t prod;     // act_west * weight
    fp16_t sum;      // psum_north + prod

    fp16_mul i_mul (
        .a (act_west),
        .b (weight),
        .y (prod)
    );

    fp16_add i_add (
        .a (psum_north),
        .b (prod),
        .y (sum)
    );

    always_ff @(posedge clk) begin
        if (!rst) begin
            weight     <= '0;
            act_east   <= '0;
            psum_south <= '0;
        end else begin
            if (weight_en)
                weight <= weight_in;
            // One register stage on both paths
            if (compute) begin
                act_east   <= act_west;
                psum_south <= sum;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/fp16_add.sv */
/* Half-precision adder, combinational
   Same-sign addition with alignment and carry normalization, opposite signs give +0 */
`timescale 1ns/1ps
`default_nettype none

module fp16_add (
    input  fp16_pkg::fp16_t a,
    input  fp16_pkg::fp16_t b,
    output fp16_pkg::fp16_t y
);

    import fp16_pkg::*;

    fp16_t            big;        // Larger magnitude operand
    fp16_t            lesser;     // Smaller magnitude operand
    logic [EXP_W-1:0] exp_diff;
    logic [MAN_W:0]   sig_small;  // Smaller significand after alignment
    logic [MAN_W+1:0] sig_sum;    // One extra bit for the carry
    logic [EXP_W-1:0] exp_inc;    // Exponent after a carry

    // Order by magnitude, sign bit left out
    assign {big, lesser} = (a[EXP_W+MAN_W-1:0] < b[EXP_W+MAN_W-1:0]) ? {b, a} : {a, b};

    assign exp_diff  = big.exp - lesser.exp;   // Never negative after ordering
    assign sig_small = {1'b1, lesser.man} >> exp_diff;
    assign sig_sum   = {1'b1, big.man} + sig_small;
    assign exp_inc   = big.exp + 1'b1;

    always_comb begin
        if (lesser.exp == '0) begin
            // Zero always sorts low, so the other one is big
            y = big;
        end else if (big.exp == EXP_W'(EXP_MAX)) begin
            y.sign = big.sign;
            y.exp  = EXP_W'(EXP_MAX);
            y.man  = '0;
        end else if (big.sign != lesser.sign) begin
            y = '0;   // No subtraction path
        end else if (sig_sum[MAN_W+1]) begin
            // Carry out, renormalize by one place
            y.sign = big.sign;
            y.exp  = exp_inc;
            y.man  = (exp_inc == EXP_W'(EXP_MAX)) ? '0 : sig_sum[MAN_W:1];
        end else begin
            y.sign = big.sign;
            y.exp  = big.exp;
            y.man  = sig_sum[MAN_W-1:0];   // Hidden bit dropped
        end
    end

endmodule

`default_nettype wire

/* verilog/fp16_mul.sv */
/* Half-precision multiplier, combinational
   Truncates, flushes underflow to signed zero and saturates to signed infinity */
`timescale 1ns/1ps
`default_nettype none

module fp16_mul (
    input  fp16_pkg::fp16_t a,
    input  fp16_pkg::fp16_t b,
    output fp16_pkg::fp16_t y
);

    import fp16_pkg::*;

    logic [PROD_W-1:0] prod;      // Hidden-bit significand product
    logic              carry;     // Product landed in [2,4)
    logic [MAN_W-1:0]  man_norm;  // Normalized, truncated fraction
    logic [EXP_W+1:0]  exp_sum;   // ea + eb + carry, still biased twice
    logic              is_zero;
    logic              is_ovf;

    // Both significands carry the implied leading one
    assign prod  = {1'b1, a.man} * {1'b1, b.man};
    assign carry = prod[PROD_W-1];

    // Drop the leading one, the rest below is cut off
    assign man_norm = carry ? prod[PROD_W-2 -: MAN_W]
                            : prod[PROD_W-3 -: MAN_W];

    // Two spare bits keep the sum from wrapping
    assign exp_sum = {2'b00, a.exp} + {2'b00, b.exp} + {{(EXP_W+1){1'b0}}, carry};

    // Result exponent below 1 means exp_sum at or under the bias
    assign is_zero = (a.exp == '0) || (b.exp == '0) ||
                     (exp_sum <= (EXP_W+2)'(EXP_BIAS));

    // Result exponent of EXP_MAX or more
    assign is_ovf = exp_sum >= (EXP_W+2)'(EXP_MAX + EXP_BIAS);

    always_comb begin
        y.sign = a.sign ^ b.sign;   // Sign kept for zero and infinity too
        if (is_zero) begin
            y.exp = '0;
            y.man = '0;
        end else if (is_ovf) begin
            y.exp = EXP_W'(EXP_MAX);
            y.man = '0;
        end else begin
            // Remove one bias, fits in EXP_W after the range checks
            y.exp = EXP_W'(exp_sum - (EXP_W+2)'(EXP_BIAS));
            y.man = man_norm;
        end
    end

endmodule

`default_nettype wire

/* verilog/sa_pkg.sv */
/* Systolic array definitions
   Array size, run length, matrix word and controller states */
`default_nettype none

package sa_pkg;

    // Square array edge
    localparam int N         = 2;

    // Compute cycles per product, 2N+1
    localparam int RUN_STEPS = 2 * N + 1;

    // Activation feeder depth per row, column of A plus skew
    localparam int FEED_LEN  = 2 * N - 1;

    // Bottom-of-column delay registers that line up the products
    localparam int DLY_LEN   = 2 * N - 2;

    // Step counter width
    localparam int STEP_W    = $clog2(RUN_STEPS);

    // 2x2 matrix, row-major, m00 in the top bits
    typedef struct packed {
        fp16_pkg::fp16_t m00;
        fp16_pkg::fp16_t m01;
        fp16_pkg::fp16_t m10;
        fp16_pkg::fp16_t m11;
    } mat_t;

    // Controller sequence
    typedef enum logic [1:0] {
        IDLE,   // Waiting for go
        LOAD,   // Weights and feeders loaded
        RUN,    // Array stepping
        DONE    // Result valid, one cycle
    } ctrl_state_t;

endpackage

`default_nettype wire

/* verilog/fp16_pkg.sv */
/* Half-precision float definitions
   Field widths, bias, special exponents and the packed fp16 word */
`default_nettype none

package fp16_pkg;

    // Simplified IEEE half precision, no subnormals
    localparam int EXP_W    = 5;                  // Exponent field width
    localparam int MAN_W    = 10;                 // Stored mantissa width
    localparam int EXP_BIAS = 15;                 // Exponent bias

    // Exponent of all ones marks infinity
    localparam int EXP_MAX  = 31;

    // Two 11-bit hidden-bit significands multiplied
    localparam int PROD_W   = 2 * (MAN_W + 1);    // 22 bits

    // One half-precision word, sign on top
    // Exponent 0 is read as zero whatever the mantissa holds
    typedef struct packed {
        logic             sign;   // 1 means negative
        logic [EXP_W-1:0] exp;    // Biased exponent
        logic [MAN_W-1:0] man;    // Fraction, hidden bit dropped
    } fp16_t;

    // Total width is 1 + EXP_W + MAN_W = 16
    // Lower EXP_W+MAN_W bits give the magnitude for ordering

endpackage

`default_nettype wire
